//--- src/rvPkg.sv
package rvPkg;

    typedef logic [63:0] xlenT;
    typedef logic [31:0] instT;
    typedef logic [4:0]  regAddrT;
    typedef logic [7:0]  byteMaskT;
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;
    typedef logic [6:0]  funct7T;

    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opImm32  = 7'b0011011;
    localparam opcodeT opReg    = 7'b0110011;
    localparam opcodeT opReg32  = 7'b0111011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;

    // access width in funct3[1:0], bit 2 marks zero extension
    typedef enum funct3T {
        f3Byte   = 3'b000,
        f3Half   = 3'b001,
        f3Word   = 3'b010,
        f3Double = 3'b011,
        f3ByteU  = 3'b100,
        f3HalfU  = 3'b101
    } funct3LoadStoreT;

endpackage

//--- src/memIf.sv
`timescale 1ns/1ps

interface memIf;

    rvPkg::xlenT     addr;
    rvPkg::xlenT     wdata;
    rvPkg::byteMaskT wmask;
    logic            we;
    rvPkg::xlenT     rdata;

    modport execUnit (
        output addr, wdata, wmask, we,
        input  rdata
    );

    modport dataMem (
        input  addr, wdata, wmask, we,
        output rdata
    );

endinterface

//--- src/immDecode.sv
`timescale 1ns/1ps

module immDecode (
    input  rvPkg::instT    inst,
    output rvPkg::xlenT    immI,
    output rvPkg::xlenT    immS,
    output rvPkg::xlenT    immB,
    output rvPkg::xlenT    immU,
    output rvPkg::xlenT    immJ,
    output rvPkg::funct3T  funct3,
    output rvPkg::funct7T  funct7,
    output rvPkg::regAddrT rd,
    output rvPkg::regAddrT rs1Addr,
    output rvPkg::regAddrT rs2Addr
);

    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rd      = inst[11:7];
    assign rs1Addr = inst[19:15];
    assign rs2Addr = inst[24:20];

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input                  clk,
    input                  rstN,
    input  rvPkg::regAddrT rs1Addr,
    input  rvPkg::regAddrT rs2Addr,
    output rvPkg::xlenT    rs1Data,
    output rvPkg::xlenT    rs2Data,
    input  logic           we,
    input  rvPkg::regAddrT wAddr,
    input  rvPkg::xlenT    wData
);

    rvPkg::xlenT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (we && wAddr != 5'd0) begin   // x0 stays zero
            regs[wAddr] <= wData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

endmodule

//--- src/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
    parameter int memWords = 64
) (
    input         clk,
    memIf.dataMem mem
);

    localparam int idxW = $clog2(memWords);

    rvPkg::xlenT words [memWords];
    logic [idxW-1:0] wordIdx;

    assign wordIdx = mem.addr[3 +: idxW];   // wraps past memWords

    always_ff @(posedge clk) begin
        if (mem.we) begin
            for (int i = 0; i < 8; i++) begin
                if (mem.wmask[i])
                    words[wordIdx][8*i +: 8] <= mem.wdata[8*i +: 8];
            end
        end
    end

    assign mem.rdata = words[wordIdx];

endmodule

//--- src/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  rvPkg::xlenT pc,
    input  rvPkg::instT inst,
    input  rvPkg::xlenT rs1,
    input  rvPkg::xlenT rs2,
    output logic        wen,
    output rvPkg::xlenT wdata,
    output logic        branchTaken,
    output rvPkg::xlenT branchTarget,
    memIf.execUnit      mem
);

    rvPkg::xlenT immI, immS, immB, immU, immJ;
    rvPkg::funct3T funct3;
    rvPkg::funct7T funct7;
    rvPkg::opcodeT opcode;
    rvPkg::funct3LoadStoreT lsKind;
    rvPkg::xlenT sum, diff, prod, immSum, pcPlus4;
    rvPkg::xlenT effAddr, alignedAddr, loadLanes;
    rvPkg::byteMaskT sizeMask;
    logic [5:0] laneShift;

    function automatic rvPkg::xlenT sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [31:0] sra32(input logic [31:0] v, input logic [4:0] sh);
        return $signed(v) >>> sh;
    endfunction

    immDecode fields (
        .inst    (inst),
        .immI    (immI),
        .immS    (immS),
        .immB    (immB),
        .immU    (immU),
        .immJ    (immJ),
        .funct3  (funct3),
        .funct7  (funct7),
        .rd      (),
        .rs1Addr (),
        .rs2Addr ()
    );

    assign opcode  = inst[6:0];
    assign lsKind  = rvPkg::funct3LoadStoreT'(funct3);
    assign sum     = rs1 + rs2;
    assign diff    = rs1 - rs2;
    assign prod    = rs1 * rs2;     // low half also serves mulw
    assign immSum  = rs1 + immI;
    assign pcPlus4 = pc + 64'd4;
    assign effAddr = (opcode == rvPkg::opStore) ? rs1 + immS : immSum;

    // align down to access size
    always_comb begin
        alignedAddr = effAddr;
        case (funct3[1:0])
            2'b00: sizeMask = 8'h01;
            2'b01: begin
                sizeMask       = 8'h03;
                alignedAddr[0] = 1'b0;
            end
            2'b10: begin
                sizeMask         = 8'h0f;
                alignedAddr[1:0] = 2'b00;
            end
            default: begin
                sizeMask         = 8'hff;
                alignedAddr[2:0] = 3'b000;
            end
        endcase
    end

    assign laneShift = {alignedAddr[2:0], 3'b000};
    assign loadLanes = mem.rdata >> laneShift;
    assign mem.addr  = alignedAddr;
    assign mem.wdata = rs2 << laneShift;
    assign mem.wmask = sizeMask << alignedAddr[2:0];

    always_comb begin
        wen          = 1'b0;
        wdata        = '0;
        branchTaken  = 1'b0;
        branchTarget = pc + immB;
        mem.we       = 1'b0;
        case (opcode)
            rvPkg::opLui: begin
                wen   = 1'b1;
                wdata = immU;
            end
            rvPkg::opAuipc: begin
                wen   = 1'b1;
                wdata = pc + immU;
            end
            rvPkg::opJal: begin
                wen          = 1'b1;
                wdata        = pcPlus4;
                branchTaken  = 1'b1;
                branchTarget = pc + immJ;
            end
            rvPkg::opJalr: begin
                wen          = (funct3 == 3'b000);
                wdata        = pcPlus4;
                branchTaken  = (funct3 == 3'b000);
                branchTarget = {immSum[63:1], 1'b0};
            end
            rvPkg::opBranch: begin
                case (funct3)
                    3'b000: branchTaken = (rs1 == rs2);
                    3'b001: branchTaken = (rs1 != rs2);
                    3'b100: branchTaken = ($signed(rs1) < $signed(rs2));
                    3'b101: branchTaken = ($signed(rs1) >= $signed(rs2));
                    3'b110: branchTaken = (rs1 < rs2);
                    3'b111: branchTaken = (rs1 >= rs2);
                    default: branchTaken = 1'b0;
                endcase
            end
            rvPkg::opLoad: begin
                wen = 1'b1;
                case (lsKind)
                    rvPkg::f3Byte:   wdata = {{56{loadLanes[7]}}, loadLanes[7:0]};
                    rvPkg::f3Half:   wdata = {{48{loadLanes[15]}}, loadLanes[15:0]};
                    rvPkg::f3Word:   wdata = sext32(loadLanes[31:0]);
                    rvPkg::f3Double: wdata = loadLanes;
                    rvPkg::f3ByteU:  wdata = {56'd0, loadLanes[7:0]};
                    rvPkg::f3HalfU:  wdata = {48'd0, loadLanes[15:0]};
                    default:         wen = 1'b0;   // lwu not in subset
                endcase
            end
            rvPkg::opStore: begin
                mem.we = lsKind inside {rvPkg::f3Byte, rvPkg::f3Half,
                                        rvPkg::f3Word, rvPkg::f3Double};
            end
            rvPkg::opImm: begin
                wen = 1'b1;
                case (funct3)
                    3'b000: wdata = immSum;
                    3'b010: wdata = {63'd0, $signed(rs1) < $signed(immI)};
                    3'b011: wdata = {63'd0, rs1 < immI};
                    3'b100: wdata = rs1 ^ immI;
                    3'b110: wdata = rs1 | immI;
                    3'b111: wdata = rs1 & immI;
                    3'b001: begin
                        wen   = (funct7[6:1] == 6'b000000);
                        wdata = rs1 << immI[5:0];
                    end
                    default: begin
                        if (funct7[6:1] == 6'b000000)
                            wdata = rs1 >> immI[5:0];
                        else if (funct7[6:1] == 6'b010000)
                            wdata = $signed(rs1) >>> immI[5:0];
                        else
                            wen = 1'b0;
                    end
                endcase
            end
            rvPkg::opImm32: begin
                wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b001}: wdata = sext32(rs1[31:0] << immI[4:0]);
                    {7'b0000000, 3'b101}: wdata = sext32(rs1[31:0] >> immI[4:0]);
                    {7'b0100000, 3'b101}: wdata = sext32(sra32(rs1[31:0], immI[4:0]));
                    default: begin
                        wen   = (funct3 == 3'b000);   // addiw takes any imm
                        wdata = sext32(immSum[31:0]);
                    end
                endcase
            end
            rvPkg::opReg: begin
                wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: wdata = sum;
                    {7'b0100000, 3'b000}: wdata = diff;
                    {7'b0000001, 3'b000}: wdata = prod;
                    {7'b0000000, 3'b001}: wdata = rs1 << rs2[5:0];
                    {7'b0000000, 3'b010}: wdata = {63'd0, $signed(rs1) < $signed(rs2)};
                    {7'b0000000, 3'b011}: wdata = {63'd0, rs1 < rs2};
                    {7'b0000000, 3'b100}: wdata = rs1 ^ rs2;
                    {7'b0000000, 3'b101}: wdata = rs1 >> rs2[5:0];
                    {7'b0100000, 3'b101}: wdata = $signed(rs1) >>> rs2[5:0];
                    {7'b0000000, 3'b110}: wdata = rs1 | rs2;
                    {7'b0000000, 3'b111}: wdata = rs1 & rs2;
                    default:              wen = 1'b0;
                endcase
            end
            rvPkg::opReg32: begin
                wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: wdata = sext32(sum[31:0]);
                    {7'b0100000, 3'b000}: wdata = sext32(diff[31:0]);
                    {7'b0000001, 3'b000}: wdata = sext32(prod[31:0]);
                    {7'b0000000, 3'b001}: wdata = sext32(rs1[31:0] << rs2[4:0]);
                    {7'b0000000, 3'b101}: wdata = sext32(rs1[31:0] >> rs2[4:0]);
                    {7'b0100000, 3'b101}: wdata = sext32(sra32(rs1[31:0], rs2[4:0]));
                    default:              wen = 1'b0;
                endcase
            end
            default: wen = 1'b0;   // outside subset, falls through
        endcase
    end

endmodule

//--- src/rvCore.sv
`timescale 1ns/1ps

module rvCore #(
    parameter int          memWords = 64,
    parameter rvPkg::xlenT resetPc  = '0
) (
    input                  clk,
    input                  rstN,
    output rvPkg::xlenT    instrAddr,
    input  rvPkg::instT    instr,
    output logic           retireWen,
    output rvPkg::regAddrT retireRd,
    output rvPkg::xlenT    retireData
);

    rvPkg::xlenT pc;
    rvPkg::xlenT branchTarget;
    rvPkg::xlenT rs1Data, rs2Data;
    rvPkg::instT execInst;
    rvPkg::regAddrT rs1Addr, rs2Addr;
    logic branchTaken;

    memIf dmem ();

    // nothing issues while in reset, keeps stores off
    assign execInst = rstN ? instr : '0;

    immDecode regFields (
        .inst    (execInst),
        .immI    (),
        .immS    (),
        .immB    (),
        .immU    (),
        .immJ    (),
        .funct3  (),
        .funct7  (),
        .rd      (retireRd),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr)
    );

    regFile regs (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .we      (retireWen),
        .wAddr   (retireRd),
        .wData   (retireData)
    );

    execUnit exec (
        .pc           (pc),
        .inst         (execInst),
        .rs1          (rs1Data),
        .rs2          (rs2Data),
        .wen          (retireWen),
        .wdata        (retireData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .mem          (dmem.execUnit)
    );

    dataMem #(
        .memWords (memWords)
    ) dataStore (
        .clk (clk),
        .mem (dmem.dataMem)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            pc <= resetPc;
        else
            pc <= branchTaken ? branchTarget : pc + 64'd4;
    end

    assign instrAddr = pc;

endmodule

//--- testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);   // release away from the rising edge
        rstN = 1'b1;
    end

endmodule

//--- testbench/rvCore_asserts.sv
`timescale 1ns/1ps

module rvCore_asserts (
    input logic        clk,
    input logic        rstN,
    input logic [63:0] pc,
    input logic [31:0] inst,
    input logic        memWe
);

    localparam logic [6:0] opcStore = 7'b0100011;

    pcEven: assert property (@(posedge clk) disable iff (!rstN) pc[0] == 1'b0)
        else $error("pc bit 0 is set, pc %h", pc);

    storeOnly: assert property (@(posedge clk) disable iff (!rstN)
        memWe |-> inst[6:0] == opcStore)
        else $error("memory write enable high for opcode %h", inst[6:0]);

    quietInReset: assert property (@(posedge clk) !rstN |-> !memWe)
        else $error("memory write enable high during reset");

endmodule

//--- testbench/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;

    localparam int          numInsts = 2000;
    localparam int          memWords = 64;
    localparam logic [63:0] resetPc  = 64'd0;

    localparam logic [6:0] opcLoad   = 7'h03;
    localparam logic [6:0] opcStore  = 7'h23;
    localparam logic [6:0] opcImm    = 7'h13;
    localparam logic [6:0] opcImm32  = 7'h1b;
    localparam logic [6:0] opcReg    = 7'h33;
    localparam logic [6:0] opcReg32  = 7'h3b;
    localparam logic [6:0] opcBranch = 7'h63;
    localparam logic [6:0] opcLui    = 7'h37;
    localparam logic [6:0] opcAuipc  = 7'h17;
    localparam logic [6:0] opcJal    = 7'h6f;
    localparam logic [6:0] opcJalr   = 7'h67;

    logic        clk;
    logic        rstN;
    logic [31:0] instr;
    logic [63:0] instrAddr;
    logic        retireWen;
    logic [4:0]  retireRd;
    logic [63:0] retireData;

    logic [31:0] lfsr = 32'hfdda73ea;
    logic [63:0] mreg [32];
    logic [63:0] mmem [memWords];
    logic [63:0] mpc;
    int          errors = 0;

    tbClock clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    rvCore #(
        .memWords (memWords),
        .resetPc  (resetPc)
    ) UUT (
        .clk        (clk),
        .rstN       (rstN),
        .instrAddr  (instrAddr),
        .instr      (instr),
        .retireWen  (retireWen),
        .retireRd   (retireRd),
        .retireData (retireData)
    );

    bind rvCore rvCore_asserts checks (
        .clk   (clk),
        .rstN  (rstN),
        .pc    (pc),
        .inst  (execInst),
        .memWe (dmem.we)
    );

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsrStep(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] genInst(input int n);
        logic [31:0] sel, rd, rs1, rs2, imm, u, f3, k;
        logic [6:0]  f7;
        sel = randBits(5);
        rd  = randBits(3);   // x0..x7 only
        rs1 = randBits(3);
        rs2 = randBits(3);
        imm = randBits(12);
        u   = randBits(20);
        f3  = randBits(3);
        k   = randBits(4);
        if (n < 16)   // seed registers
            return sel[0] ? {u[19:0], rd[4:0], opcLui}
                          : {imm[11:0], rs1[4:0], 3'd0, rd[4:0], opcImm};
        if (n < 16 + memWords) begin
            k = (n - 16) * 8;   // sd x0 over every doubleword
            return {k[11:5], 5'd0, 5'd0, 3'd3, k[4:0], opcStore};
        end
        if (sel < 6) begin
            if (f3[2:0] == 3'd1)
                imm[11:6] = 6'd0;
            if (f3[2:0] == 3'd5)
                imm[11:6] = {1'b0, k[0], 4'd0};
            return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opcImm};
        end
        if (sel < 8) begin
            // addiw, slliw, srliw, sraiw
            f3 = (k[1:0] == 2'd0) ? 32'd0 : (k[1:0] == 2'd1) ? 32'd1 : 32'd5;
            if (k[1:0] != 2'd0)
                imm[11:5] = {1'b0, k[1:0] == 2'd3, 5'd0};
            return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opcImm32};
        end
        if (sel < 16) begin
            if (sel < 14) begin
                k = k % 32'd11;
            end else begin
                k = k % 32'd6;
                if (k > 3)
                    k = k + 3;   // srlw, sraw
            end
            f3 = (k < 3) ? 32'd0 : (k < 8) ? k - 2 : (k == 8) ? 32'd5 : k - 3;
            f7 = (k == 1 || k == 8) ? 7'h20 : (k == 2) ? 7'h01 : 7'h00;
            return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], (sel < 14) ? opcReg : opcReg32};
        end
        case (sel)
            16: return {u[19:0], rd[4:0], opcLui};
            17: return {u[19:0], rd[4:0], opcAuipc};
            18: return {u[19:0], rd[4:0], opcJal};
            19: return {imm[11:0], rs1[4:0], 3'd0, rd[4:0], opcJalr};
            20, 21, 22: return {u[6:0], rs2[4:0], rs1[4:0], f3[2:0] | {f3[1], 2'b00},
                                u[11:7], opcBranch};
            23, 24, 25, 26: begin
                f3 = f3 % 32'd6;
                return {imm[11:0], k[3] ? 5'd0 : rs1[4:0], f3[2:0], rd[4:0], opcLoad};
            end
            27, 28, 29: return {imm[11:5], rs2[4:0], k[3] ? 5'd0 : rs1[4:0], 1'b0, f3[1:0],
                                imm[4:0], opcStore};
            default: return sel[0] ? {7'h01, rs2[4:0], rs1[4:0], 3'd4, rd[4:0], opcReg}
                                   : {u[19:0], imm[4:0], 7'h73};   // div or system
        endcase
    endfunction

    function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] x, input logic [63:0] y);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        sx = x;
        sy = y;
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[5:0];
            3'd2: return {63'd0, sx < sy};
            3'd3: return {63'd0, x < y};
            3'd4: return x ^ y;
            3'd5: begin
                if (alt)
                    return sx >>> y[5:0];
                return x >> y[5:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic [63:0] alu32(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] x, input logic [63:0] y);
        logic [31:0]        r;
        logic signed [31:0] sx;
        sx = x[31:0];
        case (f3)
            3'd0: r = alt ? x[31:0] - y[31:0] : x[31:0] + y[31:0];
            3'd1: r = x[31:0] << y[4:0];
            default: begin
                if (alt)
                    r = sx >>> y[4:0];
                else
                    r = x[31:0] >> y[4:0];
            end
        endcase
        return {{32{r[31]}}, r};
    endfunction

    function automatic logic branchTakes(input logic [2:0] f3, input logic [63:0] x,
                                         input logic [63:0] y);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        sx = x;
        sy = y;
        case (f3)
            3'd0: return x == y;
            3'd1: return x != y;
            3'd4: return sx < sy;
            3'd5: return sx >= sy;
            3'd6: return x < y;
            3'd7: return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [63:0] loadValue(input logic [63:0] addr, input logic [2:0] f3);
        logic [63:0] v;
        int          lane;
        lane = int'(addr[2:0]);
        lane = lane - lane % (1 << f3[1:0]);   // align down
        v = mmem[(addr >> 3) % memWords] >> (8 * lane);
        case (f3)
            3'd0: return {{56{v[7]}}, v[7:0]};
            3'd1: return {{48{v[15]}}, v[15:0]};
            3'd2: return {{32{v[31]}}, v[31:0]};
            3'd4: return {56'd0, v[7:0]};
            3'd5: return {48'd0, v[15:0]};
            default: return v;
        endcase
    endfunction

    task automatic storeValue(input logic [31:0] i);
        logic [63:0] addr;
        logic [63:0] data;
        int          lane;
        int          size;
        addr = mreg[i[19:15]] + {{52{i[31]}}, i[31:25], i[11:7]};
        data = mreg[i[24:20]];
        size = 1 << i[13:12];
        lane = int'(addr[2:0]);
        lane = lane - lane % size;
        for (int k = 0; k < size; k++)
            mmem[(addr >> 3) % memWords][8 * (lane + k) +: 8] = data[8 * k +: 8];
    endtask

    task automatic predict(input logic [31:0] i, output logic wen, output logic [63:0] res,
                           output logic [63:0] npc);
        logic [63:0] a, b, immI, immU, immJ, immB, p;
        logic [2:0]  f3;
        logic [6:0]  f7;
        a    = mreg[i[19:15]];
        b    = mreg[i[24:20]];
        f3   = i[14:12];
        f7   = i[31:25];
        immI = {{52{i[31]}}, i[31:20]};
        immU = {{32{i[31]}}, i[31:12], 12'h000};
        immJ = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        immB = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        p    = a * b;
        wen  = 1'b1;
        res  = '0;
        npc  = mpc + 64'd4;
        case (i[6:0])
            opcLui:   res = immU;
            opcAuipc: res = mpc + immU;
            opcJal: begin
                res = npc;
                npc = mpc + immJ;
            end
            opcJalr: begin
                res = npc;
                npc = (a + immI) & ~64'd1;
            end
            opcBranch: begin
                wen = 1'b0;
                if (branchTakes(f3, a, b))
                    npc = mpc + immB;
            end
            opcLoad:  res = loadValue(a + immI, f3);
            opcImm:   res = alu64(f3, f3 == 3'd5 && i[30], a, immI);
            opcImm32: res = alu32(f3, f3 == 3'd5 && i[30], a, immI);
            opcReg: begin
                if (f7 == 7'h01) begin
                    res = p;
                    wen = (f3 == 3'd0);   // div family not supported
                end else begin
                    res = alu64(f3, i[30], a, b);
                end
            end
            opcReg32: res = (f7 == 7'h01) ? {{32{p[31]}}, p[31:0]} : alu32(f3, i[30], a, b);
            default:  wen = 1'b0;   // stores and anything outside the subset
        endcase
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    initial begin
        logic [31:0] cur;
        logic [63:0] expData;
        logic [63:0] nextPc;
        logic        expWen;
        int          waitCnt;
        for (int r = 0; r < 32; r++)
            mreg[r] = '0;
        for (int w = 0; w < memWords; w++)
            mmem[w] = '0;
        mpc   = resetPc;
        cur   = genInst(0);
        instr = {7'd0, 5'd0, 5'd0, 3'd3, 5'd0, opcStore};   // sd x0 offered during reset

        waitCnt = 0;
        while (rstN !== 1'b1 && waitCnt < 10) begin
            @(negedge clk);
            instr = cur;
            #1;
            waitCnt++;
        end
        if (rstN !== 1'b1) begin
            errors++;
            $display("reset was still asserted after 10 cycles");
        end else begin
            checkValue("instrAddr", instrAddr, resetPc);
        end

        for (int n = 0; n < numInsts && rstN === 1'b1; n++) begin
            predict(cur, expWen, expData, nextPc);
            checkValue("instrAddr", instrAddr, mpc);
            checkValue("retireWen", {63'd0, retireWen}, {63'd0, expWen});
            if (expWen) begin
                checkValue("retireRd", {59'd0, retireRd}, {59'd0, cur[11:7]});
                checkValue("retireData", retireData, expData);
            end
            if (cur[6:0] == opcStore)
                storeValue(cur);
            if (expWen && cur[11:7] != 5'd0)
                mreg[cur[11:7]] = expData;
            mpc = nextPc;
            @(negedge clk);
            cur   = genInst(n + 1);
            instr = cur;
            #1;   // let the combinational path settle
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- rvCore.f
src/rvPkg.sv
src/memIf.sv
src/immDecode.sv
src/regFile.sv
src/dataMem.sv
src/execUnit.sv
src/rvCore.sv
testbench/tbClock.sv
testbench/rvCore_asserts.sv
testbench/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# builds the rvCore testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rvCoreTb -Mdir obj_dir -f rvCore.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/VrvCoreTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
